// ==== intra4_pick_top.f ====
+incdir+testbench
logic/intra4_pkg.sv
logic/intra4_pred.sv
logic/intra4_rd_eval.sv
logic/intra4_neighbors.sv
logic/intra4_ctrl.sv
logic/intra4_pick_top.sv
testbench/tb_intra4_pick.sv

// ==== logic/intra4_ctrl.sv ====
//----------------------------
// Subblock sequencer, source extraction,
// output storage and score accumulation
//----------------------------
`timescale 1ns/10ps

module intra4_ctrl
    import intra4_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_i,
    input  logic [MB_PIX*MB_PIX*PIX_W-1:0] ysrc_i,
    input  blk4_u                          pred_i [NUM_MODES],
    input  logic [MODE_W-1:0]              best_mode_i,
    input  logic [SCORE_W-1:0]             best_score_i,
    input  logic [LAMBDA_W-1:0]            lambda_mode_i,
    output logic                           init_o,
    output logic                           eval_o,
    output logic                           store_o,
    output logic [SUB_IDX_W-1:0]           sub_idx_o,
    output blk4_u                          src_o,
    output blk4_u                          chosen_o,
    output logic [MB_PIX*MB_PIX*PIX_W-1:0] yout_o,
    output logic [NUM_SUB*MODE_W-1:0]      mode_o,
    output logic [SCORE_W-1:0]             score_o,
    output logic                           done_o
);

    logic [ST_W-1:0] state;
    logic [1:0]      bx;
    logic [1:0]      by;

    assign bx = sub_idx_o[1:0];
    assign by = sub_idx_o[3:2];

    // Strobes decoded from the state
    assign init_o  = (state == ST_INIT);
    assign eval_o  = (state == ST_EVAL);
    assign store_o = (state == ST_STORE);

    //----------------------------
    // Source rows of the current subblock
    //----------------------------
    always_comb begin
        for (int y = 0; y < SUB_PIX; y++) begin
            src_o.row[y] = ysrc_i[ROW_W * (16 * by + 4 * y + bx) +: ROW_W];
        end
    end

    assign chosen_o = pred_i[best_mode_i];

    //----------------------------
    // Sequencer and result storage
    //----------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            sub_idx_o <= '0;
            yout_o    <= '0;
            mode_o    <= '0;
            score_o   <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        state <= ST_INIT;
                    end
                end
                ST_INIT: begin
                    sub_idx_o <= '0;
                    score_o   <= SCORE_W'(MB_BASE_COST) * SCORE_W'(lambda_mode_i);
                    state     <= ST_LOAD;
                end
                ST_LOAD: begin
                    state <= ST_EVAL;
                end
                ST_EVAL: begin
                    state <= ST_STORE;
                end
                ST_STORE: begin
                    for (int y = 0; y < SUB_PIX; y++) begin
                        yout_o[ROW_W * (16 * by + 4 * y + bx) +: ROW_W] <= chosen_o.row[y];
                    end
                    mode_o[MODE_W * sub_idx_o +: MODE_W] <= best_mode_i;
                    score_o <= score_o + best_score_i;
                    if (sub_idx_o == SUB_IDX_W'(NUM_SUB - 1)) begin
                        // Last subblock done
                        done_o <= 1'b1;
                        state  <= ST_IDLE;
                    end else begin
                        sub_idx_o <= sub_idx_o + 1'b1;
                        state     <= ST_LOAD;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/intra4_neighbors.sv ====
//----------------------------
// Top line, left column and corner
// pixel context for the current subblock
//----------------------------
`timescale 1ns/10ps

module intra4_neighbors
    import intra4_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    init_i,
    input  logic                    store_i,
    input  logic [SUB_IDX_W-1:0]    sub_idx_i,
    input  blk4_u                   chosen_i,
    input  logic [MB_PIX*PIX_W-1:0] top_i,
    input  logic [MB_PIX*PIX_W-1:0] left_i,
    input  logic [PIX_W-1:0]        top_left_i,
    output logic [ROW_W-1:0]        top_px_o,
    output logic [ROW_W-1:0]        left_px_o,
    output logic [PIX_W-1:0]        corner_o
);

    logic [SUB_PIX-1:0][ROW_W-1:0] top_line;
    logic [SUB_PIX-1:0][ROW_W-1:0] left_border;
    logic [ROW_W-1:0]              left_q;
    logic [PIX_W-1:0]              corner_q;
    logic [PIX_W-1:0]              top_left_q;
    logic [1:0]                    bx;
    logic [1:0]                    by;

    assign bx = sub_idx_i[1:0];
    assign by = sub_idx_i[3:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            top_line    <= '0;
            left_border <= '0;
            left_q      <= '0;
            corner_q    <= '0;
            top_left_q  <= '0;
        end else if (init_i) begin
            top_line    <= top_i;
            left_border <= left_i;
            top_left_q  <= top_left_i;
        end else if (store_i) begin
            // Old top pixel at 4bx+3 is the up-left pixel of the next block
            corner_q     <= top_line[bx][ROW_W-1 -: PIX_W];
            top_line[bx] <= chosen_i.row[SUB_PIX-1];
            left_q       <= {chosen_i.px[15], chosen_i.px[11], chosen_i.px[7], chosen_i.px[3]};
        end
    end

    //----------------------------
    // Context for sub_idx_i
    //----------------------------
    assign top_px_o  = top_line[bx];
    assign left_px_o = (bx == 2'd0) ? left_border[by] : left_q;

    always_comb begin
        if (bx != 2'd0) begin
            corner_o = corner_q;
        end else if (by == 2'd0) begin
            corner_o = top_left_q;
        end else begin
            corner_o = left_border[by - 2'd1][ROW_W-1 -: PIX_W];
        end
    end

endmodule

// ==== logic/intra4_pick_top.sv ====
//----------------------------
// Intra4 mode picker top level,
// instances and wiring
//----------------------------
`timescale 1ns/10ps

module intra4_pick_top
    import intra4_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_i,
    input  logic [MB_PIX*MB_PIX*PIX_W-1:0] ysrc_i,
    input  logic [MB_PIX*PIX_W-1:0]        top_i,
    input  logic [MB_PIX*PIX_W-1:0]        left_i,
    input  logic [PIX_W-1:0]               top_left_i,
    input  logic [LAMBDA_W-1:0]            lambda_mode_i,
    output logic [MB_PIX*MB_PIX*PIX_W-1:0] yout_o,
    output logic [NUM_SUB*MODE_W-1:0]      mode_o,
    output logic [SCORE_W-1:0]             score_o,
    output logic                           done_o
);

    logic                 init;
    logic                 eval;
    logic                 store;
    logic [SUB_IDX_W-1:0] sub_idx;
    blk4_u                src;
    blk4_u                chosen;
    blk4_u                pred [NUM_MODES];
    logic [ROW_W-1:0]     top_px;
    logic [ROW_W-1:0]     left_px;
    logic [PIX_W-1:0]     corner;
    logic [MODE_W-1:0]    best_mode;
    logic [SCORE_W-1:0]   best_score;

    intra4_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .ysrc_i        (ysrc_i),
        .pred_i        (pred),
        .best_mode_i   (best_mode),
        .best_score_i  (best_score),
        .lambda_mode_i (lambda_mode_i),
        .init_o        (init),
        .eval_o        (eval),
        .store_o       (store),
        .sub_idx_o     (sub_idx),
        .src_o         (src),
        .chosen_o      (chosen),
        .yout_o        (yout_o),
        .mode_o        (mode_o),
        .score_o       (score_o),
        .done_o        (done_o)
    );

    intra4_neighbors u_neighbors (
        .clk        (clk),
        .rst_n      (rst_n),
        .init_i     (init),
        .store_i    (store),
        .sub_idx_i  (sub_idx),
        .chosen_i   (chosen),
        .top_i      (top_i),
        .left_i     (left_i),
        .top_left_i (top_left_i),
        .top_px_o   (top_px),
        .left_px_o  (left_px),
        .corner_o   (corner)
    );

    intra4_pred u_pred (
        .top_px_i   (top_px),
        .left_px_i  (left_px),
        .top_left_i (corner),
        .pred_o     (pred)
    );

    intra4_rd_eval u_rd_eval (
        .clk           (clk),
        .rst_n         (rst_n),
        .eval_i        (eval),
        .src_i         (src),
        .pred_i        (pred),
        .lambda_mode_i (lambda_mode_i),
        .best_mode_o   (best_mode),
        .best_score_o  (best_score)
    );

endmodule

// ==== logic/intra4_pkg.sv ====
//----------------------------
// Shared widths, mode codes, mode costs,
// sequencer state codes and the 4x4 block
// union for the intra4 mode picker
//----------------------------
package intra4_pkg;

    localparam int PIX_W     = 8;
    localparam int MB_PIX    = 16;
    localparam int SUB_PIX   = 4;
    localparam int NUM_SUB   = 16;
    localparam int NUM_MODES = 4;
    localparam int MODE_W    = 2;
    localparam int SSE_W     = 21;
    localparam int LAMBDA_W  = 16;
    localparam int SCORE_W   = 48;
    localparam int ROW_W     = SUB_PIX * PIX_W;
    localparam int SUB_IDX_W = 4;

    localparam logic [MODE_W-1:0] MODE_DC = 2'd0;
    localparam logic [MODE_W-1:0] MODE_TM = 2'd1;
    localparam logic [MODE_W-1:0] MODE_VE = 2'd2;
    localparam logic [MODE_W-1:0] MODE_HE = 2'd3;

    // Fixed rate per mode in mode code order
    localparam logic [NUM_MODES-1:0][10:0] MODE_COST = {11'd1874, 11'd1723, 11'd1151, 11'd40};
    localparam int MB_BASE_COST = 211;

    // Sequencer states
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE  = 3'd0;
    localparam logic [ST_W-1:0] ST_INIT  = 3'd1;
    localparam logic [ST_W-1:0] ST_LOAD  = 3'd2;
    localparam logic [ST_W-1:0] ST_EVAL  = 3'd3;
    localparam logic [ST_W-1:0] ST_STORE = 3'd4;

    // One 4x4 block with pixel (x,y) at y*4+x and at byte x of row y
    typedef union packed {
        logic [SUB_PIX*SUB_PIX-1:0][PIX_W-1:0] px;
        logic [SUB_PIX-1:0][ROW_W-1:0]         row;
    } blk4_u;

endpackage

// ==== logic/intra4_pred.sv ====
//----------------------------
// DC, TM, VE and HE predictors for
// one 4x4 subblock, combinational
//----------------------------
`timescale 1ns/10ps

module intra4_pred
    import intra4_pkg::*;
(
    input  logic [ROW_W-1:0] top_px_i,
    input  logic [ROW_W-1:0] left_px_i,
    input  logic [PIX_W-1:0] top_left_i,
    output blk4_u            pred_o [NUM_MODES]
);

    logic [SUB_PIX-1:0][PIX_W-1:0] top_px;
    logic [SUB_PIX-1:0][PIX_W-1:0] left_px;
    logic [PIX_W+2:0]              dc_sum;
    logic [PIX_W-1:0]              dc_val;

    assign top_px  = top_px_i;
    assign left_px = left_px_i;

    //----------------------------
    // DC
    //----------------------------
    always_comb begin
        dc_sum = (PIX_W+3)'(4);
        for (int i = 0; i < SUB_PIX; i++) begin
            dc_sum = dc_sum + (PIX_W+3)'(top_px[i]) + (PIX_W+3)'(left_px[i]);
        end
    end

    assign dc_val = dc_sum[PIX_W+2:3];

    //----------------------------
    // TM, VE, HE
    //----------------------------
    always_comb begin
        logic signed [PIX_W+1:0] tm;
        for (int y = 0; y < SUB_PIX; y++) begin
            for (int x = 0; x < SUB_PIX; x++) begin
                tm = $signed({2'b00, top_px[x]}) + $signed({2'b00, left_px[y]})
                   - $signed({2'b00, top_left_i});
                // Clip to the pixel range
                if (tm < 0) begin
                    pred_o[MODE_TM].px[y*SUB_PIX+x] = '0;
                end else if (tm > 255) begin
                    pred_o[MODE_TM].px[y*SUB_PIX+x] = '1;
                end else begin
                    pred_o[MODE_TM].px[y*SUB_PIX+x] = tm[PIX_W-1:0];
                end
                pred_o[MODE_DC].px[y*SUB_PIX+x] = dc_val;
                pred_o[MODE_VE].px[y*SUB_PIX+x] = top_px[x];
                pred_o[MODE_HE].px[y*SUB_PIX+x] = left_px[y];
            end
        end
    end

endmodule

// ==== logic/intra4_rd_eval.sv ====
//----------------------------
// Per-mode SSE, reduced RD score and
// registered best-mode selection
//----------------------------
`timescale 1ns/10ps

module intra4_rd_eval
    import intra4_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                eval_i,
    input  blk4_u               src_i,
    input  blk4_u               pred_i [NUM_MODES],
    input  logic [LAMBDA_W-1:0] lambda_mode_i,
    output logic [MODE_W-1:0]   best_mode_o,
    output logic [SCORE_W-1:0]  best_score_o
);

    logic [SSE_W-1:0]   sse   [NUM_MODES];
    logic [SCORE_W-1:0] score [NUM_MODES];
    logic [MODE_W-1:0]  best_mode;
    logic [SCORE_W-1:0] best_score;

    //----------------------------
    // Distortion and score
    //----------------------------
    always_comb begin
        logic [PIX_W-1:0]   ad;
        logic [2*PIX_W-1:0] sq;
        for (int m = 0; m < NUM_MODES; m++) begin
            sse[m] = '0;
            for (int i = 0; i < SUB_PIX*SUB_PIX; i++) begin
                if (src_i.px[i] > pred_i[m].px[i]) begin
                    ad = src_i.px[i] - pred_i[m].px[i];
                end else begin
                    ad = pred_i[m].px[i] - src_i.px[i];
                end
                sq     = ad * ad;
                sse[m] = sse[m] + SSE_W'(sq);
            end
            // 256 * SSE + rate term
            score[m] = (SCORE_W'(sse[m]) << 8)
                     + SCORE_W'(MODE_COST[m]) * SCORE_W'(lambda_mode_i);
        end
    end

    // Strict compare keeps the lower mode code on a tie
    always_comb begin
        best_mode  = MODE_DC;
        best_score = score[0];
        for (int m = 1; m < NUM_MODES; m++) begin
            if (score[m] < best_score) begin
                best_mode  = MODE_W'(m);
                best_score = score[m];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_mode_o  <= '0;
            best_score_o <= '0;
        end else if (eval_i) begin
            best_mode_o  <= best_mode;
            best_score_o <= best_score;
        end
    end

endmodule

// ==== testbench/tb_intra4_model.svh ====
//----------------------------
// Reference model for the intra4 picker
// with predictors, reduced RD score, tie order
// and neighbor rotation per subblock
//----------------------------
`ifndef TB_INTRA4_MODEL_SVH
`define TB_INTRA4_MODEL_SVH

function automatic int pred_pixel(int mode, int t, int l, int c, int dc);
    int tm;
    tm = t + l - c;
    if (mode == int'(MODE_DC)) return dc;
    if (mode == int'(MODE_TM)) return (tm < 0) ? 0 : ((tm > 255) ? 255 : tm);
    if (mode == int'(MODE_VE)) return t;
    return l;
endfunction

// Fills exp_y, exp_mode and exp_score from the current case
task automatic run_model();
    int     t [4];
    int     l [4];
    int     c;
    int     dc;
    int     bx;
    int     by;
    int     best;
    int     d;
    longint sse;
    longint sc;
    longint best_sc;
    exp_score = longint'(MB_BASE_COST) * lam;
    for (int n = 0; n < NUM_SUB; n++) begin
        bx = n % 4;
        by = n / 4;
        dc = 4;
        for (int i = 0; i < 4; i++) begin
            t[i] = (by == 0) ? top_pix[4*bx+i] : exp_y[(4*by-1)*16 + 4*bx+i];
            l[i] = (bx == 0) ? left_pix[4*by+i] : exp_y[(4*by+i)*16 + 4*bx-1];
            dc   = dc + t[i] + l[i];
        end
        dc = dc >> 3;
        if (bx == 0 && by == 0) c = tl_pix;
        else if (by == 0) c = top_pix[4*bx-1];
        else if (bx == 0) c = left_pix[4*by-1];
        else c = exp_y[(4*by-1)*16 + 4*bx-1];
        best    = 0;
        best_sc = 0;
        for (int m = 0; m < NUM_MODES; m++) begin
            sse = 0;
            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    d   = src_pix[(4*by+y)*16 + 4*bx+x] - pred_pixel(m, t[x], l[y], c, dc);
                    sse = sse + d * d;
                end
            end
            sc = 256 * sse + longint'(MODE_COST[m]) * lam;
            // Lower code wins a tie
            if (m == 0 || sc < best_sc) begin
                best    = m;
                best_sc = sc;
            end
        end
        exp_mode[n] = best;
        exp_score   = exp_score + best_sc;
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                exp_y[(4*by+y)*16 + 4*bx+x] = pred_pixel(best, t[x], l[y], c, dc);
            end
        end
    end
endtask

`endif

// ==== testbench/tb_intra4_pick.sv ====
//----------------------------
// Testbench for the intra4 mode picker
// with clock, reset, case table loop, checks,
// watchdog and reporting
//----------------------------
`timescale 1ns/10ps

module tb_intra4_pick
    import intra4_pkg::*;
();

    localparam int NUM_CASES = 7;
    localparam int K_FLAT    = 0;
    localparam int K_GRAD    = 1;
    localparam int K_RAND    = 2;
    localparam int K_VE      = 3;
    localparam int K_HE      = 4;
    localparam int K_TM      = 5;
    localparam int K_DC      = 6;

    logic           clk;
    logic           rst_n;
    logic           start_i;
    logic [2047:0]  ysrc_i;
    logic [127:0]   top_i;
    logic [127:0]   left_i;
    logic [7:0]     top_left_i;
    logic [15:0]    lambda_mode_i;
    logic [2047:0]  yout_o;
    logic [31:0]    mode_o;
    logic [47:0]    score_o;
    logic           done_o;

    int     src_pix [256];
    int     top_pix [16];
    int     left_pix [16];
    int     tl_pix;
    int     lam;
    int     exp_y [256];
    int     exp_mode [16];
    longint exp_score;
    int     errors;
    int     test_errs;
    int     tests_failed;

    // kind, top base, top step, left base, left step, top_left, fill, lambda, target mode
    int case_tbl [NUM_CASES][9] = '{
        '{K_FLAT, 77, 0, 77, 0, 77, 77, 0, 0},
        '{K_GRAD, 10, 3, 15, 4, 12, 30, 25, -1},
        '{K_RAND, 5, 37, 9, 53, 200, 0, 60, -1},
        '{K_VE, 20, 90, 180, 7, 100, 0, 4, 2},
        '{K_HE, 60, 9, 30, 70, 60, 0, 4, 3},
        '{K_TM, 40, 6, 50, 5, 40, 0, 4, 1},
        '{K_DC, 100, 20, 100, 20, 100, 130, 100, 0}
    };

    `include "tb_intra4_model.svh"

    intra4_pick_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .ysrc_i        (ysrc_i),
        .top_i         (top_i),
        .left_i        (left_i),
        .top_left_i    (top_left_i),
        .lambda_mode_i (lambda_mode_i),
        .yout_o        (yout_o),
        .mode_o        (mode_o),
        .score_o       (score_o),
        .done_o        (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (NUM_CASES * 60 + 100) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", NUM_CASES * 60 + 100);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_val(string name, logic [2047:0] exp_v, logic [2047:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERR time=%0t %s expected=%0h actual=%0h", $time, name, exp_v, act_v);
            errors++;
            test_errs++;
        end
    endtask

    function automatic string kind_name(int k);
        string names [7] = '{"flat", "gradient", "random", "vertical", "horizontal",
                             "planar", "dc"};
        return names[k];
    endfunction

    task automatic build_case(int c);
        int kind;
        kind   = case_tbl[c][0];
        tl_pix = case_tbl[c][5];
        lam    = case_tbl[c][7];
        for (int i = 0; i < 16; i++) begin
            top_pix[i]  = (case_tbl[c][1] + case_tbl[c][2] * i) & 255;
            left_pix[i] = (case_tbl[c][3] + case_tbl[c][4] * i) & 255;
            top_i[8*i +: 8]  = top_pix[i];
            left_i[8*i +: 8] = left_pix[i];
        end
        for (int i = 0; i < 256; i++) begin
            case (kind)
                K_GRAD:  src_pix[i] = case_tbl[c][6] + 3 * (i % 16) + 5 * (i / 16);
                K_RAND:  src_pix[i] = $urandom & 255;
                K_VE:    src_pix[i] = top_pix[i % 16];
                K_HE:    src_pix[i] = left_pix[i / 16];
                K_TM:    src_pix[i] = top_pix[i % 16] + left_pix[i / 16] - tl_pix;
                default: src_pix[i] = case_tbl[c][6];
            endcase
            src_pix[i]        = src_pix[i] & 255;
            ysrc_i[8*i +: 8] = src_pix[i];
        end
        top_left_i    = tl_pix;
        lambda_mode_i = lam;
    endtask

    task automatic check_outputs();
        logic [2047:0] ey;
        logic [31:0]   em;
        for (int i = 0; i < 256; i++) ey[8*i +: 8] = exp_y[i];
        for (int n = 0; n < 16; n++) em[2*n +: 2] = exp_mode[n];
        check_val("yout_o", ey, yout_o);
        check_val("mode_o", em, mode_o);
        check_val("score_o", exp_score, score_o);
    endtask

    initial begin
        int seed;
        int cyc;
        int hits;
        seed          = $urandom(55606);
        errors        = 0;
        tests_failed  = 0;
        rst_n         = 1'b0;
        start_i       = 1'b0;
        ysrc_i        = '0;
        top_i         = '0;
        left_i        = '0;
        top_left_i    = '0;
        lambda_mode_i = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Outputs after reset
        test_errs = 0;
        check_val("yout_o", '0, yout_o);
        check_val("mode_o", '0, mode_o);
        check_val("score_o", '0, score_o);
        check_val("done_o", '0, done_o);
        $display("Test reset: %s", (test_errs == 0) ? "ok" : "FAILED");
        if (test_errs != 0) tests_failed++;

        for (int c = 0; c < NUM_CASES; c++) begin
            test_errs = 0;
            build_case(c);
            run_model();
            start_i = 1'b1;
            @(posedge clk);
            #1;
            start_i = 1'b0;
            cyc     = 0;
            while (!done_o && cyc < 60) begin
                @(posedge clk);
                #1;
                cyc++;
                // Extra start while busy
                if (cyc == 10) start_i = 1'b1;
                else if (cyc == 11) start_i = 1'b0;
            end
            if (!done_o) begin
                $display("Test %0d: done_o did not arrive within 60 cycles of start", c);
                errors++;
                test_errs++;
            end
            check_val("done_latency", 49, cyc);
            check_outputs();
            if (case_tbl[c][8] >= 0) check_val("mode_o[1:0]", case_tbl[c][8], mode_o[1:0]);

            // Outputs hold while inputs change
            ysrc_i        = ~ysrc_i;
            lambda_mode_i = lam + 1;
            repeat (4) begin
                @(posedge clk);
                #1;
                check_val("done_o", '0, done_o);
            end
            check_outputs();

            hits = 0;
            for (int n = 0; n < 16; n++) begin
                if (case_tbl[c][8] >= 0 && int'(mode_o[2*n +: 2]) == case_tbl[c][8]) hits++;
            end
            $display("Test %0d %s: %s, %0d subblocks in target mode", c,
                     kind_name(case_tbl[c][0]), (test_errs == 0) ? "ok" : "FAILED", hits);
            if (test_errs != 0) tests_failed++;
        end

        $display("%0d tests, %0d failed, %0d mismatches", NUM_CASES + 1, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
